// File: compile.f
+incdir+verification
common/coh_pkg.sv
cache/l1_cache.sv
logic/bus_arbiter.sv
directory/directory_ctrl.sv
logic/coh_top.sv
verification/tb_coh_top.sv

// File: Bender.yml
package:
  name: coh_subsystem

sources:
  - common/coh_pkg.sv
  - cache/l1_cache.sv
  - logic/bus_arbiter.sv
  - directory/directory_ctrl.sv
  - logic/coh_top.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/tb_coh_top.sv

// File: verification/coh_ref_model.svh
`ifndef COH_REF_MODEL_SVH
`define COH_REF_MODEL_SVH

// expected memory contents as of the last acknowledged write
data_t ref_mem [64] = '{default: '0};

logic [31:0] rng_state = 32'haa2d29d6;

function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

function automatic logic [31:0] rand_next();
    rng_state = xorshift32(rng_state);
    return rng_state;
endfunction

// a read returns the last acknowledged write to that word from either core
function automatic data_t ref_access(input bus_op_e op, input addr_t addr, input data_t wdata);
    if (op == BUS_WRITE) begin
        ref_mem[addr] = wdata;
    end
    return ref_mem[addr];
endfunction

task automatic check_equal(input string name, input logic [31:0] got,
                           input logic [31:0] expected);
    if (got !== expected) begin
        $display("Mismatch at %0t ns: %s got 0x%08h, expected 0x%08h",
                 $time, name, got, expected);
        $display("TEST RESULT: FAIL");
        $fatal(1, "compare failed");
    end
endtask

`endif

// File: verification/tb_coh_top.sv
`timescale 1ns/1ps

module tb_coh_top import coh_pkg::*; ();

    localparam int RAND_OPS      = 200;
    localparam int DIRECTED_REQS = 21;
    localparam int TOTAL_REQS    = DIRECTED_REQS + 2 * RAND_OPS;
    localparam int CYCLE_LIMIT   = 40 * TOTAL_REQS + 100;

    logic    sys_clk;
    logic    sys_rst;
    wb_req_t wb_req [2];
    wb_rsp_t wb_rsp [2];

    int         cycle_count;
    int         issued_count [2];
    int         ack_count    [2];
    logic [1:0] prev_ack;

    logic  rnd_we   [2][RAND_OPS];
    addr_t rnd_addr [2][RAND_OPS];
    data_t rnd_data [2][RAND_OPS];

    `include "coh_ref_model.svh"

    coh_top i_dut (
        .sys_clk    (sys_clk),
        .sys_rst    (sys_rst),
        .core0_wb_i (wb_req[0]),
        .core0_wb_o (wb_rsp[0]),
        .core1_wb_i (wb_req[1]),
        .core1_wb_o (wb_rsp[1])
    );

    always #20 sys_clk = ~sys_clk;

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    // wishbone master holds the request until ack then drops stb
    task automatic wb_access(input int core, input logic we, input addr_t adr, input data_t dat);
        wb_req[core].cyc = 1'b1;
        wb_req[core].stb = 1'b1;
        wb_req[core].we  = we;
        wb_req[core].adr = adr;
        wb_req[core].dat = dat;
        issued_count[core]++;
        do begin
            @(negedge sys_clk);
        end while (!wb_rsp[core].ack);
        @(negedge sys_clk);
        wb_req[core].cyc = 1'b0;
        wb_req[core].stb = 1'b0;
    endtask

    task automatic run_random(input int core);
        for (int i = 0; i < RAND_OPS; i++) begin
            wb_access(core, rnd_we[core][i], rnd_addr[core][i], rnd_data[core][i]);
        end
    endtask

    task automatic check_ack_counts();
        check_equal("core0 ack count", ack_count[0], issued_count[0]);
        check_equal("core1 ack count", ack_count[1], issued_count[1]);
    endtask

    // protocol rules and read data as seen just before each rising edge
    always @(posedge sys_clk) begin
        data_t expected;
        if (sys_rst) begin
            prev_ack = '0;
        end else begin
            for (int c = 0; c < 2; c++) begin
                if (wb_rsp[c].ack) begin
                    if (!(wb_req[c].cyc && wb_req[c].stb)) begin
                        fail_run($sformatf("core%0d ack was high while stb was low", c));
                    end else if (prev_ack[c]) begin
                        fail_run($sformatf("core%0d ack was high in two cycles in a row", c));
                    end else begin
                        ack_count[c]++;
                        if (wb_req[c].we) begin
                            void'(ref_access(BUS_WRITE, wb_req[c].adr, wb_req[c].dat));
                        end else begin
                            expected = ref_access(BUS_READ, wb_req[c].adr, '0);
                            check_equal($sformatf("core%0d_wb_o.dat", c), wb_rsp[c].dat,
                                        expected);
                        end
                    end
                end
                prev_ack[c] = wb_rsp[c].ack;
            end
        end
    end

    always @(posedge sys_clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            fail_run($sformatf("timeout after %0d cycles, a request was never acknowledged",
                               cycle_count));
        end
    end

    initial begin
        logic [31:0] r;
        data_t       v0;
        data_t       v1;
        sys_clk         = 1'b0;
        sys_rst         = 1'b1;
        wb_req[0]       = '0;
        wb_req[1]       = '0;
        cycle_count     = 0;
        issued_count[0] = 0;
        issued_count[1] = 0;
        ack_count[0]    = 0;
        ack_count[1]    = 0;
        prev_ack        = '0;

        // core 0 stays in the lower half of memory and core 1 in the upper half
        for (int i = 0; i < RAND_OPS; i++) begin
            for (int c = 0; c < 2; c++) begin
                r              = rand_next();
                rnd_we[c][i]   = r[0];
                rnd_addr[c][i] = {c[0], r[8:4]};
                rnd_data[c][i] = rand_next();
            end
        end

        repeat (4) @(posedge sys_clk);
        @(negedge sys_clk);
        sys_rst = 1'b0;
        @(negedge sys_clk);

        // unwritten words read as zero
        wb_access(0, 1'b0, 6'd5, '0);
        wb_access(0, 1'b0, 6'd17, '0);
        wb_access(0, 1'b0, 6'd40, '0);
        wb_access(1, 1'b0, 6'd9, '0);
        wb_access(1, 1'b0, 6'd33, '0);
        wb_access(1, 1'b0, 6'd62, '0);
        check_ack_counts();

        // write then miss and hit on the same core
        v0 = rand_next();
        wb_access(0, 1'b1, 6'd12, v0);
        wb_access(0, 1'b0, 6'd12, '0);
        wb_access(0, 1'b0, 6'd12, '0);
        v1 = rand_next();
        wb_access(1, 1'b1, 6'd45, v1);
        wb_access(1, 1'b0, 6'd45, '0);
        wb_access(1, 1'b0, 6'd45, '0);
        check_ack_counts();

        // stale copy in core 0 must be invalidated
        wb_access(0, 1'b0, 6'd20, '0);
        v0 = rand_next();
        wb_access(1, 1'b1, 6'd20, v0);
        wb_access(0, 1'b0, 6'd20, '0);
        check_ack_counts();

        // both cores share, then both write
        wb_access(0, 1'b0, 6'd27, '0);
        wb_access(1, 1'b0, 6'd27, '0);
        v0 = rand_next();
        v1 = rand_next();
        wb_access(0, 1'b1, 6'd27, v0);
        wb_access(1, 1'b1, 6'd27, v1);
        wb_access(0, 1'b0, 6'd27, '0);
        wb_access(1, 1'b0, 6'd27, '0);
        check_ack_counts();

        fork
            run_random(0);
            run_random(1);
        join
        check_ack_counts();

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// File: logic/coh_top.sv
`timescale 1ns/1ps

module coh_top import coh_pkg::*; #(
    parameter int CACHE_LINES = 8,
    parameter int MEM_WORDS   = 64
) (
    input  logic    sys_clk,
    input  logic    sys_rst,
    input  wb_req_t core0_wb_i,
    output wb_rsp_t core0_wb_o,
    input  wb_req_t core1_wb_i,
    output wb_rsp_t core1_wb_o
);

    bus_req_t cache0_req;
    bus_req_t cache1_req;
    bus_rsp_t cache0_rsp;
    bus_rsp_t cache1_rsp;
    bus_req_t dir_req;
    core_id_t dir_core;
    bus_rsp_t dir_rsp;
    inv_t     inv0;
    inv_t     inv1;

    l1_cache #(
        .CACHE_LINES (CACHE_LINES)
    ) i_cache0 (
        .sys_clk_i (sys_clk),
        .sys_rst_i (sys_rst),
        .wb_i      (core0_wb_i),
        .wb_o      (core0_wb_o),
        .bus_req_o (cache0_req),
        .bus_rsp_i (cache0_rsp),
        .inv_i     (inv0)
    );

    l1_cache #(
        .CACHE_LINES (CACHE_LINES)
    ) i_cache1 (
        .sys_clk_i (sys_clk),
        .sys_rst_i (sys_rst),
        .wb_i      (core1_wb_i),
        .wb_o      (core1_wb_o),
        .bus_req_o (cache1_req),
        .bus_rsp_i (cache1_rsp),
        .inv_i     (inv1)
    );

    bus_arbiter i_arbiter (
        .sys_clk_i  (sys_clk),
        .sys_rst_i  (sys_rst),
        .req0_i     (cache0_req),
        .req1_i     (cache1_req),
        .rsp0_o     (cache0_rsp),
        .rsp1_o     (cache1_rsp),
        .dir_req_o  (dir_req),
        .dir_core_o (dir_core),
        .dir_rsp_i  (dir_rsp)
    );

    directory_ctrl #(
        .MEM_WORDS (MEM_WORDS)
    ) i_directory (
        .sys_clk_i (sys_clk),
        .sys_rst_i (sys_rst),
        .req_i     (dir_req),
        .core_i    (dir_core),
        .rsp_o     (dir_rsp),
        .inv0_o    (inv0),
        .inv1_o    (inv1)
    );

endmodule

// File: directory/directory_ctrl.sv
`timescale 1ns/1ps

module directory_ctrl import coh_pkg::*; #(
    parameter int MEM_WORDS = 64
) (
    input  logic     sys_clk_i,
    input  logic     sys_rst_i,
    input  bus_req_t req_i,
    input  core_id_t core_i,
    output bus_rsp_t rsp_o,
    output inv_t     inv0_o,
    output inv_t     inv1_o
);

    dir_state_e state_q;
    data_t      mem       [MEM_WORDS];
    sharers_t   sharers_q [MEM_WORDS];
    data_t      rdata_q;

    sharers_t req_bit;
    sharers_t inv_mask;
    logic     serve_write;

    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = '0;
        end
    end

    assign req_bit     = sharers_t'(1) << core_i;
    assign serve_write = (state_q == D_SERVE) && (req_i.op == BUS_WRITE);

    // every sharer except the writer
    assign inv_mask = sharers_q[req_i.addr] & ~req_bit;

    // the request stays granted and stable until done
    always_ff @(posedge sys_clk_i or posedge sys_rst_i) begin
        if (sys_rst_i) begin
            state_q <= D_IDLE;
            for (int i = 0; i < MEM_WORDS; i++) begin
                sharers_q[i] <= '0;
            end
        end else begin
            case (state_q)
                D_IDLE: begin
                    if (req_i.valid) begin
                        state_q <= D_SERVE;
                    end
                end
                D_SERVE: begin
                    state_q <= D_DONE;
                    if (serve_write) begin
                        sharers_q[req_i.addr] <= req_bit;
                    end else begin
                        sharers_q[req_i.addr] <= sharers_q[req_i.addr] | req_bit;
                    end
                end
                D_DONE: begin
                    state_q <= D_IDLE;
                end
                default: begin
                    state_q <= D_IDLE;
                end
            endcase
        end
    end

    // main memory
    always @(posedge sys_clk_i) begin
        if (state_q == D_SERVE) begin
            if (serve_write) begin
                mem[req_i.addr] <= req_i.data;
            end else begin
                rdata_q <= mem[req_i.addr];
            end
        end
    end

    assign rsp_o.done = (state_q == D_DONE);
    assign rsp_o.data = rdata_q;

    // invalidation lands one cycle ahead of done
    assign inv0_o.valid = serve_write && inv_mask[0];
    assign inv0_o.addr  = req_i.addr;
    assign inv1_o.valid = serve_write && inv_mask[1];
    assign inv1_o.addr  = req_i.addr;

endmodule

// File: logic/bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter import coh_pkg::*; (
    input  logic     sys_clk_i,
    input  logic     sys_rst_i,
    input  bus_req_t req0_i,
    input  bus_req_t req1_i,
    output bus_rsp_t rsp0_o,
    output bus_rsp_t rsp1_o,
    output bus_req_t dir_req_o,
    output core_id_t dir_core_o,
    input  bus_rsp_t dir_rsp_i
);

    logic     busy_q;
    core_id_t grant_q;
    core_id_t last_q;
    core_id_t pick;
    bus_req_t granted_req;

    // round robin where the last served core loses a tie
    always_comb begin
        if (req0_i.valid && req1_i.valid) begin
            pick = ~last_q;
        end else if (req1_i.valid) begin
            pick = core_id_t'(1);
        end else begin
            pick = core_id_t'(0);
        end
    end

    always_ff @(posedge sys_clk_i or posedge sys_rst_i) begin
        if (sys_rst_i) begin
            busy_q  <= 1'b0;
            grant_q <= '0;
            last_q  <= core_id_t'(1);
        end else if (!busy_q) begin
            if (req0_i.valid || req1_i.valid) begin
                busy_q  <= 1'b1;
                grant_q <= pick;
            end
        end else if (dir_rsp_i.done) begin
            busy_q <= 1'b0;
            last_q <= grant_q;
        end
    end

    assign granted_req = (grant_q == core_id_t'(1)) ? req1_i : req0_i;
    assign dir_req_o   = busy_q ? granted_req : '0;
    assign dir_core_o  = grant_q;

    always_comb begin
        rsp0_o.done = busy_q && dir_rsp_i.done && (grant_q == core_id_t'(0));
        rsp0_o.data = dir_rsp_i.data;
        rsp1_o.done = busy_q && dir_rsp_i.done && (grant_q == core_id_t'(1));
        rsp1_o.data = dir_rsp_i.data;
    end

endmodule

// File: cache/l1_cache.sv
`timescale 1ns/1ps

module l1_cache import coh_pkg::*; #(
    parameter int CACHE_LINES = 8
) (
    input  logic     sys_clk_i,
    input  logic     sys_rst_i,
    input  wb_req_t  wb_i,
    output wb_rsp_t  wb_o,
    output bus_req_t bus_req_o,
    input  bus_rsp_t bus_rsp_i,
    input  inv_t     inv_i
);

    localparam int IDX_W = $clog2(CACHE_LINES);
    localparam int TAG_W = ADDR_W - IDX_W;

    typedef logic [IDX_W-1:0] idx_t;
    typedef logic [TAG_W-1:0] tag_t;

    cache_state_e           state_q;
    logic [CACHE_LINES-1:0] valid_q;
    tag_t                   tag_q  [CACHE_LINES];
    data_t                  data_q [CACHE_LINES];
    data_t                  rdata_q;
    bus_req_t               bus_req_q;

    idx_t  req_idx;
    tag_t  req_tag;
    idx_t  inv_idx;
    idx_t  fill_idx;
    logic  req_valid;
    logic  read_hit;
    logic  inv_hit;
    logic  fill;
    data_t fill_data;

    assign req_idx   = wb_i.adr[IDX_W-1:0];
    assign req_tag   = wb_i.adr[ADDR_W-1:IDX_W];
    assign req_valid = wb_i.cyc && wb_i.stb;
    assign read_hit  = !wb_i.we && valid_q[req_idx] && (tag_q[req_idx] == req_tag);

    // snoop from the directory
    assign inv_idx = inv_i.addr[IDX_W-1:0];
    assign inv_hit = inv_i.valid && (tag_q[inv_idx] == inv_i.addr[ADDR_W-1:IDX_W]);

    // writes fill the line with their own data
    assign fill      = (state_q == C_BUS) && bus_rsp_i.done;
    assign fill_idx  = bus_req_q.addr[IDX_W-1:0];
    assign fill_data = (bus_req_q.op == BUS_READ) ? bus_rsp_i.data : bus_req_q.data;

    always_ff @(posedge sys_clk_i or posedge sys_rst_i) begin
        if (sys_rst_i) begin
            state_q   <= C_IDLE;
            valid_q   <= '0;
            bus_req_q <= '0;
        end else begin
            if (inv_hit) begin
                valid_q[inv_idx] <= 1'b0;
            end
            case (state_q)
                C_IDLE: begin
                    if (req_valid) begin
                        if (read_hit) begin
                            state_q <= C_ACK;
                        end else begin
                            bus_req_q.valid <= 1'b1;
                            bus_req_q.op    <= wb_i.we ? BUS_WRITE : BUS_READ;
                            bus_req_q.addr  <= wb_i.adr;
                            bus_req_q.data  <= wb_i.dat;
                            state_q         <= C_BUS;
                        end
                    end
                end
                C_BUS: begin
                    // a snoop never meets the fill since the directory serves one request at a time
                    if (fill) begin
                        bus_req_q.valid   <= 1'b0;
                        valid_q[fill_idx] <= 1'b1;
                        state_q           <= C_ACK;
                    end
                end
                C_ACK: begin
                    state_q <= C_IDLE;
                end
                default: begin
                    state_q <= C_IDLE;
                end
            endcase
        end
    end

    // line storage and read data
    always_ff @(posedge sys_clk_i) begin
        if ((state_q == C_IDLE) && req_valid && read_hit) begin
            rdata_q <= data_q[req_idx];
        end
        if (fill) begin
            tag_q[fill_idx]  <= bus_req_q.addr[ADDR_W-1:IDX_W];
            data_q[fill_idx] <= fill_data;
            rdata_q          <= fill_data;
        end
    end

    assign wb_o.ack  = (state_q == C_ACK);
    assign wb_o.dat  = rdata_q;
    assign bus_req_o = bus_req_q;

endmodule

// File: common/coh_pkg.sv
package coh_pkg;

    localparam int ADDR_W    = 6;
    localparam int DATA_W    = 32;
    localparam int NUM_CORES = 2;

    typedef logic [ADDR_W-1:0]            addr_t;
    typedef logic [DATA_W-1:0]            data_t;
    typedef logic [NUM_CORES-1:0]         sharers_t;
    typedef logic [$clog2(NUM_CORES)-1:0] core_id_t;

    typedef enum logic {
        BUS_READ  = 1'b0,
        BUS_WRITE = 1'b1
    } bus_op_e;

    // wishbone classic request from the master
    typedef struct packed {
        logic  cyc;
        logic  stb;
        logic  we;
        addr_t adr;
        data_t dat;
    } wb_req_t;

    typedef struct packed {
        logic  ack;
        data_t dat;
    } wb_rsp_t;

    // cache to directory
    typedef struct packed {
        logic    valid;
        bus_op_e op;
        addr_t   addr;
        data_t   data;
    } bus_req_t;

    typedef struct packed {
        logic  done;
        data_t data;
    } bus_rsp_t;

    typedef struct packed {
        logic  valid;
        addr_t addr;
    } inv_t;

    typedef enum logic [1:0] {C_IDLE, C_ACK, C_BUS} cache_state_e;
    typedef enum logic [1:0] {D_IDLE, D_SERVE, D_DONE} dir_state_e;

endpackage
